// File: filelist.f
+incdir+include
src/screen_pkg.sv
src/pixel_if.sv
src/screen_regs.sv
src/pic_ram.sv
src/pixel_scan.sv
src/pixel_fifo.sv
src/screen_compose.sv
src/game_screen_top.sv
test/tb_game_screen.sv

// File: include/screen_macros.svh
// ******************************
// screen macros
// screen geometry, picture windows,
// buffer depth and APB address map
// ******************************
`ifndef SCREEN_MACROS_SVH
`define SCREEN_MACROS_SVH

`define SCREEN_W    64          // reduced screen
`define SCREEN_H    48
`define COORD_W     6           // bits per pixel coordinate

`define BG_W        32          // background, drawn at double scale
`define BG_H        24

`define START_X0    16          // start picture window
`define START_Y0    8
`define START_W     32
`define START_H     16

`define OVER_X0     16          // game-over picture window
`define OVER_Y0     20
`define OVER_W      32
`define OVER_H      8

`define FIFO_DEPTH  4
`define PIC_AW      10          // covers the largest picture

`define ADDR_CTRL   16'h0000
`define ADDR_BG     16'h1000
`define ADDR_START  16'h2000
`define ADDR_OVER   16'h3000

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# builds the game screen testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_game_screen -f filelist.f -o tb_game_screen
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_game_screen > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi

// File: src/game_screen_top.sv
// ******************************
// game_screen_top
// game screen compositor top level
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

module game_screen_top import screen_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 psel,
	input  wire                 penable,
	input  wire                 pwrite,
	input  wire  [15:0]         paddr,
	input  wire  [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	output logic                pix_valid,
	input  wire                 pix_ready,
	output logic [`COORD_W-1:0] pix_x,
	output logic [`COORD_W-1:0] pix_y,
	output logic [11:0]         pix_rgb
);

	game_mode_t         mode;
	logic               scan_en;
	logic               we_bg;
	logic               we_start;
	logic               we_over;
	logic [`PIC_AW-1:0] waddr;
	pic_word_u          wdata;
	logic [`PIC_AW-1:0] bg_addr;
	logic [`PIC_AW-1:0] start_addr;
	logic [`PIC_AW-1:0] over_addr;
	pic_word_u          bg_data;
	pic_word_u          start_data;
	pic_word_u          over_data;

	pixel_if scan_req ();               // scan to buffer
	pixel_if comp_req ();               // buffer to compositor

	screen_regs u_regs (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .mode(mode), .scan_en(scan_en), .we_bg(we_bg),
		.we_start(we_start), .we_over(we_over), .waddr(waddr), .wdata(wdata)
	);

	pixel_scan u_scan (.clk(clk), .rst(rst), .scan_en(scan_en), .mode(mode), .req(scan_req));

	pixel_fifo u_fifo (.clk(clk), .rst(rst), .in(scan_req), .out(comp_req));

	screen_compose u_compose (
		.clk(clk), .rst(rst), .req(comp_req),
		.bg_addr(bg_addr), .start_addr(start_addr), .over_addr(over_addr),
		.bg_data(bg_data), .start_data(start_data), .over_data(over_data),
		.pix_valid(pix_valid), .pix_ready(pix_ready),
		.pix_x(pix_x), .pix_y(pix_y), .pix_rgb(pix_rgb)
	);

	pic_ram #(.DEPTH(`BG_W * `BG_H)) u_bg_ram (
		.clk(clk), .we(we_bg), .waddr(waddr), .wdata(wdata),
		.raddr(bg_addr), .rdata(bg_data)
	);

	pic_ram #(.DEPTH(`START_W * `START_H)) u_start_ram (
		.clk(clk), .we(we_start), .waddr(waddr), .wdata(wdata),
		.raddr(start_addr), .rdata(start_data)
	);

	pic_ram #(.DEPTH(`OVER_W * `OVER_H)) u_over_ram (
		.clk(clk), .we(we_over), .waddr(waddr), .wdata(wdata),
		.raddr(over_addr), .rdata(over_data)
	);

endmodule

`default_nettype wire

// File: src/pic_ram.sv
// ******************************
// pic_ram
// picture memory, registered read
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

module pic_ram import screen_pkg::*; #(
	parameter int DEPTH = 256
) (
	input  wire                clk,
	input  wire                we,
	input  wire  [`PIC_AW-1:0] waddr,
	input  wire  pic_word_u    wdata,
	input  wire  [`PIC_AW-1:0] raddr,
	output pic_word_u          rdata
);

	localparam int AW = $clog2(DEPTH);

	pic_word_u mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr[AW-1:0]] <= wdata;
		rdata <= mem[raddr[AW-1:0]];        // data one cycle after the address
	end

endmodule

`default_nettype wire

// File: src/pixel_fifo.sv
// ******************************
// pixel_fifo
// fall-through request buffer
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

module pixel_fifo import screen_pkg::*; #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  wire     clk,
	input  wire     rst,
	pixel_if.sink   in,
	pixel_if.source out
);

	localparam int PW = $clog2(DEPTH);

	logic [`COORD_W-1:0] x_mem [DEPTH];
	logic [`COORD_W-1:0] y_mem [DEPTH];
	game_mode_t          mode_mem [DEPTH];
	logic [PW-1:0]       wr_ptr;
	logic [PW-1:0]       rd_ptr;
	logic [PW:0]         count;
	logic                full;
	logic                push;
	logic                pop;

	assign full = (int'(count) == DEPTH);
	assign push = in.valid && in.ready;
	assign pop  = out.valid && out.ready;

	assign in.ready  = !full;
	assign out.valid = (count != '0);
	assign out.x     = x_mem[rd_ptr];       // head seen the cycle after the push
	assign out.y     = y_mem[rd_ptr];
	assign out.mode  = mode_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			x_mem[wr_ptr]    <= in.x;
			y_mem[wr_ptr]    <= in.y;
			mode_mem[wr_ptr] <= in.mode;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		full && !pop |=> full && $stable(wr_ptr));

endmodule

`default_nettype wire

// File: src/pixel_if.sv
// ******************************
// pixel_if
// pixel request with valid/ready
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

interface pixel_if import screen_pkg::*; ();
	logic                valid;
	logic                ready;
	logic [`COORD_W-1:0] x;
	logic [`COORD_W-1:0] y;
	game_mode_t          mode;      // mode of the frame this pixel belongs to

	modport source (output valid, output x, output y, output mode, input ready);
	modport sink   (input valid, input x, input y, input mode, output ready);
endinterface

`default_nettype wire

// File: src/pixel_scan.sv
// ******************************
// pixel_scan
// walks whole frames in raster order
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

module pixel_scan import screen_pkg::*; (
	input  wire             clk,
	input  wire             rst,
	input  wire             scan_en,
	input  wire game_mode_t mode,
	pixel_if.source         req
);

	logic                active;
	logic [`COORD_W-1:0] x_q;
	logic [`COORD_W-1:0] y_q;
	game_mode_t          mode_q;
	logic                xfer;
	logic                last_x;
	logic                last_y;

	assign xfer   = req.valid && req.ready;
	assign last_x = (x_q == `COORD_W'(`SCREEN_W - 1));
	assign last_y = (y_q == `COORD_W'(`SCREEN_H - 1));

	assign req.valid = active;
	assign req.x     = x_q;
	assign req.y     = y_q;
	assign req.mode  = mode_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			active <= 1'b0;
			x_q    <= '0;
			y_q    <= '0;
			mode_q <= MODE_START;
		end
		else if (!active)
		begin
			if (scan_en)
			begin
				active <= 1'b1;
				x_q    <= '0;
				y_q    <= '0;
				mode_q <= mode;     // latched for the whole frame
			end
		end
		else if (xfer)
		begin
			if (!last_x)
				x_q <= x_q + 1'b1;
			else
			begin
				x_q <= '0;
				if (!last_y)
					y_q <= y_q + 1'b1;
				else
				begin
					y_q <= '0;
					// disable only stops us at a frame end
					if (scan_en)
						mode_q <= mode;
					else
						active <= 1'b0;
				end
			end
		end
	end

	a_stall_holds: assert property (@(posedge clk) disable iff (rst)
		req.valid && !req.ready |=> req.valid && $stable(req.x) && $stable(req.y));

endmodule

`default_nettype wire

// File: src/screen_compose.sv
// ******************************
// screen_compose
// reads the three pictures and mixes
// background and overlay by mode
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

module screen_compose import screen_pkg::*; (
	input  wire                 clk,
	input  wire                 rst,
	pixel_if.sink               req,
	output logic [`PIC_AW-1:0]  bg_addr,
	output logic [`PIC_AW-1:0]  start_addr,
	output logic [`PIC_AW-1:0]  over_addr,
	input  wire  pic_word_u     bg_data,
	input  wire  pic_word_u     start_data,
	input  wire  pic_word_u     over_data,
	output logic                pix_valid,
	input  wire                 pix_ready,
	output logic [`COORD_W-1:0] pix_x,
	output logic [`COORD_W-1:0] pix_y,
	output logic [11:0]         pix_rgb
);

	logic                adv;
	logic                pop;
	logic                in_start;
	logic                in_over;
	logic [`PIC_AW-1:0]  bg_a;
	logic [`PIC_AW-1:0]  st_a;
	logic [`PIC_AW-1:0]  ov_a;
	logic [`PIC_AW-1:0]  bg_q;
	logic [`PIC_AW-1:0]  st_q;
	logic [`PIC_AW-1:0]  ov_q;
	logic                s1_valid;
	logic [`COORD_W-1:0] s1_x;
	logic [`COORD_W-1:0] s1_y;
	game_mode_t          s1_mode;
	logic                s1_in_start;
	logic                s1_in_over;
	logic [2:0]          set_rgb;
	logic [3:0]          r4;
	logic [3:0]          g4;
	logic [3:0]          b4;

	assign adv       = pix_ready || !pix_valid;    // hold everything on a stall
	assign pop       = req.valid && adv;
	assign req.ready = adv;

	assign in_start = (req.x >= `START_X0) && (req.x < `START_X0 + `START_W) &&
		(req.y >= `START_Y0) && (req.y < `START_Y0 + `START_H);
	assign in_over = (req.x >= `OVER_X0) && (req.x < `OVER_X0 + `OVER_W) &&
		(req.y >= `OVER_Y0) && (req.y < `OVER_Y0 + `OVER_H);

	assign bg_a = `PIC_AW'((req.y >> 1) * `BG_W + (req.x >> 1));  // double scale
	assign st_a = in_start ?
		`PIC_AW'((req.y - `START_Y0) * `START_W + (req.x - `START_X0)) : '0;
	assign ov_a = in_over ?
		`PIC_AW'((req.y - `OVER_Y0) * `OVER_W + (req.x - `OVER_X0)) : '0;

	// keep re-reading the held pixel so rdata stays put under a stall
	assign bg_addr    = adv ? bg_a : bg_q;
	assign start_addr = adv ? st_a : st_q;
	assign over_addr  = adv ? ov_a : ov_q;

	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else if (adv)
			s1_valid <= pop;
	end

	always_ff @(posedge clk)
	begin
		if (adv)
		begin
			bg_q        <= bg_a;
			st_q        <= st_a;
			ov_q        <= ov_a;
			s1_x        <= req.x;
			s1_y        <= req.y;
			s1_mode     <= req.mode;
			s1_in_start <= in_start;
			s1_in_over  <= in_over;
		end
	end

	always_comb
	begin
		set_rgb = 3'b000;                   // play mode has no overlay
		if (s1_mode == MODE_START && s1_in_start)
			set_rgb = {start_data.mask.r_set, start_data.mask.g_set, start_data.mask.b_set};
		else if (s1_mode == MODE_OVER && s1_in_over)
			set_rgb = {over_data.mask.r_set, over_data.mask.g_set, over_data.mask.b_set};
		r4 = set_rgb[2] ? 4'hf : {bg_data.rgb.r, bg_data.rgb.r[2]};
		g4 = set_rgb[1] ? 4'hf : {bg_data.rgb.g, bg_data.rgb.g[2]};
		b4 = set_rgb[0] ? 4'hf : {bg_data.rgb.b, bg_data.rgb.b};
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			pix_valid <= 1'b0;
		else if (adv)
			pix_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		if (adv)
		begin
			pix_x   <= s1_x;
			pix_y   <= s1_y;
			pix_rgb <= {r4, g4, b4};
		end
	end

	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_rgb) &&
		$stable(pix_x) && $stable(pix_y));

endmodule

`default_nettype wire

// File: src/screen_pkg.sv
// ******************************
// screen_pkg
// game mode and picture word types
// ******************************
`default_nettype none

package screen_pkg;

	typedef enum logic [1:0] {
		MODE_START = 2'd0,
		MODE_PLAY  = 2'd1,
		MODE_OVER  = 2'd2
	} game_mode_t;                  // 3 is rejected at the register

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
	} rgb332_t;                     // background colour

	typedef struct packed {
		logic [4:0] pad;
		logic       r_set;
		logic       g_set;
		logic       b_set;
	} mask3_t;                      // overlay channel mask

	// one stored byte, read either way depending on the picture
	typedef union packed {
		rgb332_t rgb;
		mask3_t  mask;
	} pic_word_u;

endpackage

`default_nettype wire

// File: src/screen_regs.sv
// ******************************
// screen_regs
// APB slave: control register and
// picture load strobes
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

module screen_regs import screen_pkg::*; (
	input  wire                clk,
	input  wire                rst,
	input  wire                psel,
	input  wire                penable,
	input  wire                pwrite,
	input  wire  [15:0]        paddr,
	input  wire  [31:0]        pwdata,
	output logic [31:0]        prdata,
	output logic               pready,
	output logic               pslverr,
	output game_mode_t         mode,
	output logic               scan_en,
	output logic               we_bg,
	output logic               we_start,
	output logic               we_over,
	output logic [`PIC_AW-1:0] waddr,
	output pic_word_u          wdata
);

	logic        access;
	logic        wr;
	logic [15:0] base;
	logic [11:0] offs;
	logic        hit_ctrl;
	logic        hit_bg;
	logic        hit_start;
	logic        hit_over;
	logic        bad_mode;
	logic        err;

	assign access = psel && penable;            // no wait states
	assign base   = paddr & 16'hf000;
	assign offs   = paddr[11:0];

	assign hit_ctrl  = (paddr == `ADDR_CTRL);
	assign hit_bg    = (base == `ADDR_BG) && (offs < `BG_W * `BG_H);
	assign hit_start = (base == `ADDR_START) && (offs < `START_W * `START_H);
	assign hit_over  = (base == `ADDR_OVER) && (offs < `OVER_W * `OVER_H);

	assign bad_mode = hit_ctrl && pwrite && (pwdata[1:0] == 2'd3);
	assign err      = !(hit_ctrl || hit_bg || hit_start || hit_over) || bad_mode;
	assign wr       = access && pwrite && !err;

	assign pready  = access;
	assign pslverr = access && err;
	assign prdata  = hit_ctrl ? {27'd0, scan_en, 2'd0, mode} : 32'd0;  // pictures read 0

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mode    <= MODE_START;
			scan_en <= 1'b0;
		end
		else if (wr && hit_ctrl)
		begin
			mode    <= game_mode_t'(pwdata[1:0]);
			scan_en <= pwdata[4];
		end
	end

	// one-cycle strobes, address and byte follow alongside
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			we_bg    <= 1'b0;
			we_start <= 1'b0;
			we_over  <= 1'b0;
		end
		else
		begin
			we_bg    <= wr && hit_bg;
			we_start <= wr && hit_start;
			we_over  <= wr && hit_over;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			waddr <= offs[`PIC_AW-1:0];
			wdata <= pic_word_u'(pwdata[7:0]);  // low byte only
		end
	end

	a_penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
		penable |-> psel);

endmodule

`default_nettype wire

// File: test/tb_game_screen.sv
// ******************************
// tb_game_screen
// testbench for the game screen
// compositor, checks every pixel
// ******************************
`default_nettype none
`timescale 1ns/1ps
`include "screen_macros.svh"

module tb_game_screen import screen_pkg::*; ();

	localparam int SCREEN_PIX   = `SCREEN_W * `SCREEN_H;
	localparam int FRAME_LIMIT  = 20000;    // cycles per wait for pixels
	localparam int APB_LIMIT    = 16;
	localparam int QUIET_CYCLES = 100;      // window to catch stray pixels

	logic                clk;
	logic                rst;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [15:0]         paddr;
	logic [31:0]         pwdata;
	logic [31:0]         prdata;
	logic                pready;
	logic                pslverr;
	logic                pix_valid;
	logic                pix_ready;
	logic [`COORD_W-1:0] pix_x;
	logic [`COORD_W-1:0] pix_y;
	logic [11:0]         pix_rgb;

	pic_word_u  bg_pic [`BG_W * `BG_H];     // copies of the loaded pictures
	pic_word_u  start_pic [`START_W * `START_H];
	pic_word_u  over_pic [`OVER_W * `OVER_H];

	int         errors;
	int         checks;
	int         frame_pix;                  // pixels accepted in this frame
	int         exp_x;
	int         exp_y;
	bit         timed_out;
	bit         stall_on;
	game_mode_t chk_mode;

	game_screen_top DUT (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .pix_valid(pix_valid), .pix_ready(pix_ready),
		.pix_x(pix_x), .pix_y(pix_y), .pix_rgb(pix_rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	// colour the screen should show at (x, y) in mode m
	function automatic logic [11:0] expected_rgb(input int x, input int y,
		input game_mode_t m);
		pic_word_u  bgw;
		pic_word_u  ovw;
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
		bgw = bg_pic[(y / 2) * `BG_W + x / 2];
		r = {bgw.rgb.r, bgw.rgb.r[2]};
		g = {bgw.rgb.g, bgw.rgb.g[2]};
		b = {bgw.rgb.b, bgw.rgb.b};
		ovw = '0;
		if (m == MODE_START && x >= `START_X0 && x < `START_X0 + `START_W &&
			y >= `START_Y0 && y < `START_Y0 + `START_H)
			ovw = start_pic[(y - `START_Y0) * `START_W + (x - `START_X0)];
		else if (m == MODE_OVER && x >= `OVER_X0 && x < `OVER_X0 + `OVER_W &&
			y >= `OVER_Y0 && y < `OVER_Y0 + `OVER_H)
			ovw = over_pic[(y - `OVER_Y0) * `OVER_W + (x - `OVER_X0)];
		if (ovw.mask.r_set)
			r = 4'hf;
		if (ovw.mask.g_set)
			g = 4'hf;
		if (ovw.mask.b_set)
			b = 4'hf;
		return {r, g, b};
	endfunction

	// random back pressure on the pixel output
	always @(posedge clk)
	begin
		#2;
		if (stall_on)
			pix_ready = (($urandom % 4) != 0);
		else
			pix_ready = 1'b1;
	end

	// every accepted pixel against raster order and the reference colour
	always @(posedge clk)
	begin
		if (!rst && pix_valid && pix_ready)
		begin
			assert (frame_pix < SCREEN_PIX)
			else
			begin
				errors++;
				$display("pixel (%0d,%0d) arrived after the frame had ended", pix_x, pix_y);
			end
			check_value("pix_x", pix_x, exp_x);
			check_value("pix_y", pix_y, exp_y);
			check_value("pix_rgb", pix_rgb, expected_rgb(exp_x, exp_y, chk_mode));
			frame_pix++;
			if (exp_x == `SCREEN_W - 1)
			begin
				exp_x = 0;
				exp_y = (exp_y == `SCREEN_H - 1) ? 0 : exp_y + 1;
			end
			else
				exp_x++;
		end
	end

	// one APB transfer, setup then access phase
	task automatic apb_access(input bit write, input logic [15:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output bit err);
		int n;
		@(posedge clk);
		#2;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		n = 0;
		@(negedge clk);
		while (!pready && n < APB_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!pready)
		begin
			timed_out = 1'b1;
			$display("APB access to address %h never completed", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic check_registers;
		logic [31:0] rd;
		bit          err;
		apb_access(1'b0, `ADDR_CTRL, 32'h0, rd, err);      // start mode, scan off
		check_value("prdata", rd, 32'h0);
		apb_access(1'b1, `ADDR_CTRL, 32'h02, rd, err);
		check_value("pslverr", err, 0);
		apb_access(1'b0, `ADDR_CTRL, 32'h0, rd, err);
		check_value("prdata", rd, 32'h02);
		apb_access(1'b1, `ADDR_CTRL, 32'h13, rd, err);     // mode 3 refused
		check_value("pslverr", err, 1);
		apb_access(1'b1, 16'h4000, 32'h01, rd, err);       // unmapped
		check_value("pslverr", err, 1);
		apb_access(1'b0, 16'h0004, 32'h0, rd, err);
		check_value("pslverr", err, 1);
		apb_access(1'b1, `ADDR_OVER + 16'h0100, 32'h07, rd, err);  // past picture end
		check_value("pslverr", err, 1);
		apb_access(1'b0, `ADDR_BG, 32'h0, rd, err);
		check_value("pslverr", err, 0);
		check_value("prdata", rd, 32'h0);
		apb_access(1'b0, `ADDR_CTRL, 32'h0, rd, err);
		check_value("prdata", rd, 32'h02);
	endtask

	task automatic load_pictures;
		logic [31:0] w;
		logic [31:0] rd;
		bit          err;
		for (int i = 0; i < `BG_W * `BG_H; i++)
		begin
			w = $urandom;
			bg_pic[i] = w[7:0];
			apb_access(1'b1, `ADDR_BG + 16'(i), w, rd, err);
			check_value("pslverr", err, 0);
		end
		for (int i = 0; i < `START_W * `START_H; i++)
		begin
			w = $urandom;
			start_pic[i] = w[7:0];
			apb_access(1'b1, `ADDR_START + 16'(i), w, rd, err);
			check_value("pslverr", err, 0);
		end
		for (int i = 0; i < `OVER_W * `OVER_H; i++)
		begin
			w = $urandom;
			over_pic[i] = w[7:0];
			apb_access(1'b1, `ADDR_OVER + 16'(i), w, rd, err);
			check_value("pslverr", err, 0);
		end
	endtask

	task automatic wait_pixels(input int target);
		int n;
		n = 0;
		while (frame_pix < target && n < FRAME_LIMIT)
		begin
			@(negedge clk);
			n++;
		end
		if (frame_pix < target)
		begin
			timed_out = 1'b1;
			$display("timeout with %0d of %0d pixels arrived", frame_pix, target);
		end
	endtask

	// one frame in mode m, enable cleared after stop_at pixels
	task automatic run_frame(input game_mode_t m, input bit stall, input int stop_at);
		logic [31:0] rd;
		bit          err;
		chk_mode  = m;
		frame_pix = 0;
		exp_x     = 0;
		exp_y     = 0;
		stall_on  = stall;
		apb_access(1'b1, `ADDR_CTRL, {27'd0, 1'b1, 2'd0, m}, rd, err);
		check_value("pslverr", err, 0);
		apb_access(1'b0, `ADDR_CTRL, 32'h0, rd, err);
		check_value("prdata", rd, {27'd0, 1'b1, 2'd0, m});
		if (stop_at > 0)
		begin
			wait_pixels(stop_at);
			if (timed_out)
				return;
		end
		apb_access(1'b1, `ADDR_CTRL, {30'd0, m}, rd, err);
		check_value("pslverr", err, 0);
		wait_pixels(SCREEN_PIX);
		if (timed_out)
			return;
		stall_on = 1'b0;
		repeat (QUIET_CYCLES) @(negedge clk);
		check_value("frame pixel count", frame_pix, SCREEN_PIX);
	endtask

	task automatic finish_run;
		$display("errors: %0d  checks: %0d  timeouts: %0d", errors, checks, timed_out);
		if (errors == 0 && !timed_out && checks > 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	initial
	begin
		void'($urandom(32'hbadd4a3d));
		rst       = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		pix_ready = 1'b1;
		errors    = 0;
		checks    = 0;
		frame_pix = 0;
		exp_x     = 0;
		exp_y     = 0;
		timed_out = 1'b0;
		stall_on  = 1'b0;
		chk_mode  = MODE_START;
		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		@(negedge clk);
		check_value("pix_valid", pix_valid, 0);
		check_value("pslverr", pslverr, 0);
		check_registers();
		if (!timed_out)
			load_pictures();
		if (!timed_out)
			run_frame(MODE_PLAY, 1'b0, 0);
		if (!timed_out)
			run_frame(MODE_START, 1'b0, 0);
		if (!timed_out)
			run_frame(MODE_OVER, 1'b0, 0);
		if (!timed_out)
			run_frame(MODE_START, 1'b1, 1500);  // stalls, enable dropped mid-frame
		if (!timed_out)
			run_frame(MODE_OVER, 1'b1, 700);
		finish_run();
	end

endmodule

`default_nettype wire
